//--- branchHistory.sv
module branchHistory (
    input  logic                           clk,
    input  logic                           arstN,

    input  logic                           shiftEn,
    input  logic                           shiftTaken,

    output logic [tagePkg::historyLen-1:0] history
);

    // Newest outcome at bit 0
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            history <= '0;
        end else if (shiftEn) begin
            history <= {history[tagePkg::historyLen-2:0], shiftTaken};
        end
    end

endmodule

//--- branchPredictionTable.sv
module branchPredictionTable (
    input  logic                         clk,
    input  logic                         arstN,

    input  logic [tagePkg::baseBits-1:0] readIndex,
    output logic                         taken,

    input  logic                         writeEn,
    input  logic [tagePkg::baseBits-1:0] writeIndex,
    input  logic                         writeTaken,

    input  logic                         clearEn,
    input  logic [tagePkg::baseBits-1:0] clearIndex
);

    // 2-bit saturating counters, 1 is weakly not taken
    logic [1:0] counters [tagePkg::baseEntries];
    logic [1:0] current;

    assign taken = counters[readIndex][1];
    assign current = counters[writeIndex];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < tagePkg::baseEntries; i++) begin
                counters[i] <= 2'd1;
            end
        end else if (clearEn) begin
            counters[clearIndex] <= 2'd1;
        end else if (writeEn) begin
            if (writeTaken && current != 2'd3) begin
                counters[writeIndex] <= current + 2'd1;
            end else if (!writeTaken && current != 2'd0) begin
                counters[writeIndex] <= current - 2'd1;
            end
        end
    end

endmodule

//--- branchPredictorTop.sv
module branchPredictorTop (
    input  logic                            clk,
    input  logic                            arstN,

    input  logic                            predValid,
    input  logic [tagePkg::addrBits-1:0]    predAddr,
    output logic                            predReady,
    output logic                            predTaken,
    output logic [tagePkg::stageIdBits-1:0] predTageId,
    output logic [tagePkg::numStages-1:0]   predUseful,
    output logic [tagePkg::historyLen-1:0]  predHistory,

    input  logic                            updValid,
    input  logic [tagePkg::addrBits-1:0]    updAddr,
    input  logic [tagePkg::historyLen-1:0]  updHistory,
    input  logic [tagePkg::stageIdBits-1:0] updTageId,
    input  logic                            updTaken,
    input  logic                            updPred,
    input  logic [tagePkg::numStages-1:0]   updUseful,
    output logic                            updReady
);

    logic                                            baseTaken;
    logic [tagePkg::numTagged-1:0]                   tagHit;
    logic [tagePkg::numTagged-1:0]                   tagTaken;
    logic [tagePkg::numTagged-1:0]                   tagUsefulFree;
    logic                                            clearEn;
    logic [tagePkg::baseBits-1:0]                    clearIndex;
    logic                                            baseWriteEn;
    logic [tagePkg::numTagged*tagePkg::hashBits-1:0] readIndex;
    logic [tagePkg::numTagged*tagePkg::tagBits-1:0]  readTag;
    logic [tagePkg::numTagged*tagePkg::hashBits-1:0] writeIndex;
    logic [tagePkg::numTagged*tagePkg::tagBits-1:0]  writeTag;
    logic [tagePkg::numTagged-1:0]                   writeEn;
    logic [tagePkg::numTagged-1:0]                   trainEn;
    logic [tagePkg::numTagged-1:0]                   allocEn;
    logic [tagePkg::numTagged-1:0]                   usefulSet;
    logic [tagePkg::numTagged-1:0]                   usefulClr;
    logic                                            historyShift;

    tagePredictor ctrl (
        .clk(clk),
        .arstN(arstN),
        .predValid(predValid),
        .predAddr(predAddr),
        .predReady(predReady),
        .predTaken(predTaken),
        .predTageId(predTageId),
        .predUseful(predUseful),
        .updValid(updValid),
        .updAddr(updAddr),
        .updHistory(updHistory),
        .updTageId(updTageId),
        .updTaken(updTaken),
        .updPred(updPred),
        .updUseful(updUseful),
        .updReady(updReady),
        .history(predHistory),
        .baseTaken(baseTaken),
        .tagHit(tagHit),
        .tagTaken(tagTaken),
        .tagUsefulFree(tagUsefulFree),
        .clearEn(clearEn),
        .clearIndex(clearIndex),
        .baseWriteEn(baseWriteEn),
        .readIndex(readIndex),
        .readTag(readTag),
        .writeIndex(writeIndex),
        .writeTag(writeTag),
        .writeEn(writeEn),
        .trainEn(trainEn),
        .allocEn(allocEn),
        .usefulSet(usefulSet),
        .usefulClr(usefulClr),
        .historyShift(historyShift)
    );

    branchPredictionTable basePredictor (
        .clk(clk),
        .arstN(arstN),
        .readIndex(predAddr[tagePkg::baseBits-1:0]),
        .taken(baseTaken),
        .writeEn(baseWriteEn),
        .writeIndex(updAddr[tagePkg::baseBits-1:0]),
        .writeTaken(updTaken),
        .clearEn(clearEn),
        .clearIndex(clearIndex)
    );

    // Lane t is table t+1
    for (genvar t = 0; t < tagePkg::numTagged; t++) begin : tageGen
        tageTable tage (
            .clk(clk),
            .arstN(arstN),
            .readIndex(readIndex[t*tagePkg::hashBits +: tagePkg::hashBits]),
            .readTag(readTag[t*tagePkg::tagBits +: tagePkg::tagBits]),
            .hit(tagHit[t]),
            .taken(tagTaken[t]),
            .usefulFree(tagUsefulFree[t]),
            .writeEn(writeEn[t]),
            .writeIndex(writeIndex[t*tagePkg::hashBits +: tagePkg::hashBits]),
            .writeTag(writeTag[t*tagePkg::tagBits +: tagePkg::tagBits]),
            .writeTaken(updTaken),
            .trainEn(trainEn[t]),
            .allocEn(allocEn[t]),
            .usefulSet(usefulSet[t]),
            .usefulClr(usefulClr[t]),
            .clearEn(clearEn),
            .clearIndex(clearIndex[tagePkg::hashBits-1:0])
        );
    end

    branchHistory ghist (
        .clk(clk),
        .arstN(arstN),
        .shiftEn(historyShift),
        .shiftTaken(updTaken),
        .history(predHistory)
    );

endmodule

//--- run.sh
#!/usr/bin/env bash
# Build and run the branch predictor testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    -f verilog.f \
    --top-module tbBranchPredictor \
    -o simBranchPredictor
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit $status
fi

./obj_dir/simBranchPredictor
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit $status
fi

exit 0

//--- tagePkg.sv
package tagePkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Predictor geometry
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Base table plus tagged tables
    localparam int numStages = 5;
    localparam int numTagged = numStages - 1;

    // Bimodal base table, indexed by address bits 7:0
    localparam int baseEntries = 256;
    localparam int baseBits = 8;

    // Tagged tables
    localparam int tableEntries = 64;
    localparam int hashBits = 6;
    localparam int tagBits = 8;

    // Table i folds 2**(i-1) history slices, at most 8 of 8 bits
    localparam int historyLen = 64;

    // Branch PC without its low bit
    localparam int addrBits = 31;

    localparam int stageIdBits = 3;

    // One cycle per base entry; tagged tables done after the first 64
    localparam int sweepCycles = baseEntries;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Controller state
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef enum logic {
        sweeping,
        running
    } ctrlState_e;

endpackage

//--- tagePredictor.sv
module tagePredictor (
    input  logic                                             clk,
    input  logic                                             arstN,

    // Prediction channel
    input  logic                                             predValid,
    input  logic [tagePkg::addrBits-1:0]                     predAddr,
    output logic                                             predReady,
    output logic                                             predTaken,
    output logic [tagePkg::stageIdBits-1:0]                  predTageId,
    output logic [tagePkg::numStages-1:0]                    predUseful,

    // Update channel
    input  logic                                             updValid,
    input  logic [tagePkg::addrBits-1:0]                     updAddr,
    input  logic [tagePkg::historyLen-1:0]                   updHistory,
    input  logic [tagePkg::stageIdBits-1:0]                  updTageId,
    input  logic                                             updTaken,
    input  logic                                             updPred,
    input  logic [tagePkg::numStages-1:0]                    updUseful,
    output logic                                             updReady,

    // Datapath status
    input  logic [tagePkg::historyLen-1:0]                   history,
    input  logic                                             baseTaken,
    input  logic [tagePkg::numTagged-1:0]                    tagHit,
    input  logic [tagePkg::numTagged-1:0]                    tagTaken,
    input  logic [tagePkg::numTagged-1:0]                    tagUsefulFree,

    // Datapath control
    output logic                                             clearEn,
    output logic [tagePkg::baseBits-1:0]                     clearIndex,
    output logic                                             baseWriteEn,
    output logic [tagePkg::numTagged*tagePkg::hashBits-1:0]  readIndex,
    output logic [tagePkg::numTagged*tagePkg::tagBits-1:0]   readTag,
    output logic [tagePkg::numTagged*tagePkg::hashBits-1:0]  writeIndex,
    output logic [tagePkg::numTagged*tagePkg::tagBits-1:0]   writeTag,
    output logic [tagePkg::numTagged-1:0]                    writeEn,
    output logic [tagePkg::numTagged-1:0]                    trainEn,
    output logic [tagePkg::numTagged-1:0]                    allocEn,
    output logic [tagePkg::numTagged-1:0]                    usefulSet,
    output logic [tagePkg::numTagged-1:0]                    usefulClr,
    output logic                                             historyShift
);

    tagePkg::ctrlState_e              state;
    logic [tagePkg::baseBits-1:0]     sweepCount;
    logic                             predFire;
    logic                             updFire;
    logic                             taken;
    logic [tagePkg::stageIdBits-1:0]  tageId;
    logic [tagePkg::numStages-1:0]    useful;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Reset sweep
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state <= tagePkg::sweeping;
            sweepCount <= '0;
        end else if (state == tagePkg::sweeping) begin
            sweepCount <= sweepCount + 1'b1;
            if (sweepCount == tagePkg::baseBits'(tagePkg::sweepCycles - 1)) begin
                state <= tagePkg::running;
            end
        end
    end

    assign clearEn = state == tagePkg::sweeping;
    assign clearIndex = sweepCount;
    assign predReady = state == tagePkg::running;
    assign updReady = state == tagePkg::running;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Index and tag folding
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic logic [tagePkg::hashBits-1:0] foldIndex(
        input logic [tagePkg::addrBits-1:0]   addr,
        input logic [tagePkg::historyLen-1:0] hist,
        input int                             slices
    );
        logic [tagePkg::hashBits-1:0] idx;
        idx = addr[tagePkg::hashBits-1:0] ^ addr[2*tagePkg::hashBits-1:tagePkg::hashBits];
        for (int j = 0; j < slices; j++) begin
            idx ^= hist[tagePkg::hashBits*j +: tagePkg::hashBits];
        end
        return idx;
    endfunction

    function automatic logic [tagePkg::tagBits-1:0] foldTag(
        input logic [tagePkg::addrBits-1:0]   addr,
        input logic [tagePkg::historyLen-1:0] hist,
        input int                             slices
    );
        logic [tagePkg::tagBits-1:0] tag;
        tag = addr[tagePkg::tagBits-1:0];
        for (int j = 0; j < slices; j++) begin
            tag ^= hist[tagePkg::tagBits*j +: tagePkg::tagBits];
        end
        return tag;
    endfunction

    // Lookups use live history, updates the returned snapshot
    always_comb begin
        for (int t = 0; t < tagePkg::numTagged; t++) begin
            readIndex[t*tagePkg::hashBits +: tagePkg::hashBits] = foldIndex(predAddr, history, 1 << t);
            readTag[t*tagePkg::tagBits +: tagePkg::tagBits] = foldTag(predAddr, history, 1 << t);
            writeIndex[t*tagePkg::hashBits +: tagePkg::hashBits] =
                foldIndex(updAddr, updHistory, 1 << t);
            writeTag[t*tagePkg::tagBits +: tagePkg::tagBits] = foldTag(updAddr, updHistory, 1 << t);
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Provider selection
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        taken = baseTaken;
        tageId = '0;
        useful[0] = baseTaken;
        for (int t = 0; t < tagePkg::numTagged; t++) begin
            // Longest hitting history wins
            if (tagHit[t]) begin
                taken = tagTaken[t];
                tageId = tagePkg::stageIdBits'(t + 1);
            end
            useful[t+1] = taken;
        end
    end

    assign predFire = predValid && predReady;
    assign predTaken = predFire && taken;
    assign predTageId = predFire ? tageId : '0;
    assign predUseful = predFire ? useful : '0;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Update decisions
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign updFire = updValid && updReady;
    assign baseWriteEn = updFire;
    assign historyShift = updFire;
    assign writeEn = {tagePkg::numTagged{updFire}};

    always_comb begin
        logic found;
        found = 1'b0;
        allocEn = '0;
        for (int t = 0; t < tagePkg::numTagged; t++) begin
            trainEn[t] = updTageId == tagePkg::stageIdBits'(t + 1);
            usefulSet[t] = updUseful[t+1] == updTaken && updUseful[t+1] != updUseful[t];
            usefulClr[t] = updUseful[t+1] != updTaken && updUseful[t+1] != updUseful[t];
            // Lowest free table above the provider on a mispredict
            if (updTaken != updPred && !found && tagUsefulFree[t]
                    && updTageId < tagePkg::stageIdBits'(t + 1)) begin
                allocEn[t] = 1'b1;
                found = 1'b1;
            end
        end
    end

endmodule

//--- tageTable.sv
module tageTable (
    input  logic                         clk,
    input  logic                         arstN,

    // Prediction lookup
    input  logic [tagePkg::hashBits-1:0] readIndex,
    input  logic [tagePkg::tagBits-1:0]  readTag,
    output logic                         hit,
    output logic                         taken,
    output logic                         usefulFree,

    // Update port
    input  logic                         writeEn,
    input  logic [tagePkg::hashBits-1:0] writeIndex,
    input  logic [tagePkg::tagBits-1:0]  writeTag,
    input  logic                         writeTaken,
    input  logic                         trainEn,
    input  logic                         allocEn,
    input  logic                         usefulSet,
    input  logic                         usefulClr,

    input  logic                         clearEn,
    input  logic [tagePkg::hashBits-1:0] clearIndex
);

    logic [tagePkg::tableEntries-1:0] valid;
    logic [tagePkg::tableEntries-1:0] useful;
    logic [tagePkg::tagBits-1:0]      tags     [tagePkg::tableEntries];
    logic [2:0]                       counters [tagePkg::tableEntries];

    logic       writeMatch;
    logic       allocate;
    logic [2:0] current;

    assign hit = valid[readIndex] && tags[readIndex] == readTag;
    assign taken = counters[readIndex][2];

    // Allocation looks at the update-side entry
    assign usefulFree = !useful[writeIndex];

    assign writeMatch = writeEn && valid[writeIndex] && tags[writeIndex] == writeTag;
    assign allocate = writeEn && allocEn;
    assign current = counters[writeIndex];

    // Entry flags
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            valid <= '0;
            useful <= '0;
        end else if (clearEn) begin
            valid[clearIndex] <= 1'b0;
            useful[clearIndex] <= 1'b0;
        end else if (allocate) begin
            valid[writeIndex] <= 1'b1;
            useful[writeIndex] <= 1'b0;
        end else if (writeMatch && usefulSet) begin
            useful[writeIndex] <= 1'b1;
        end else if (writeMatch && usefulClr) begin
            useful[writeIndex] <= 1'b0;
        end
    end

    // Tag and counter payload
    always_ff @(posedge clk) begin
        if (allocate) begin
            tags[writeIndex] <= writeTag;
            // Weak in the resolved direction
            counters[writeIndex] <= writeTaken ? 3'd4 : 3'd3;
        end else if (writeMatch && trainEn) begin
            if (writeTaken && current != 3'd7) begin
                counters[writeIndex] <= current + 3'd1;
            end else if (!writeTaken && current != 3'd0) begin
                counters[writeIndex] <= current - 3'd1;
            end
        end
    end

endmodule

//--- tbBranchPredictor.sv
module tbBranchPredictor;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int waitLimit = 400;
    localparam int randomCycles = 300;

    logic                            clk;
    logic                            arstN;
    logic                            predValid;
    logic [tagePkg::addrBits-1:0]    predAddr;
    logic                            predReady;
    logic                            predTaken;
    logic [tagePkg::stageIdBits-1:0] predTageId;
    logic [tagePkg::numStages-1:0]   predUseful;
    logic [tagePkg::historyLen-1:0]  predHistory;
    logic                            updValid;
    logic [tagePkg::addrBits-1:0]    updAddr;
    logic [tagePkg::historyLen-1:0]  updHistory;
    logic [tagePkg::stageIdBits-1:0] updTageId;
    logic                            updTaken;
    logic                            updPred;
    logic [tagePkg::numStages-1:0]   updUseful;
    logic                            updReady;

    logic [15:0]                     lfsr;
    logic [31:0]                     bits;
    logic [tagePkg::historyLen-1:0]  modelHistory;

    // Last captured prediction
    logic                            gotTaken;
    logic [tagePkg::stageIdBits-1:0] gotTageId;
    logic [tagePkg::numStages-1:0]   gotUseful;
    logic [tagePkg::historyLen-1:0]  gotHistory;

    branchPredictorTop uut (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Helpers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Galois form, taps 16,14,13,11
    function automatic logic [15:0] lfsrNext(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic drawBits(input int n, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < n; i++) begin
            value = {value[30:0], lfsr[0]};
            lfsr = lfsrNext(lfsr);
        end
    endtask

    task automatic checkValue(input string name, input logic [63:0] expected,
                              input logic [63:0] actual);
        if (actual !== expected) begin
            $display("[FAIL] time %0t: %s expected %0h, actual %0h",
                     $time, name, expected, actual);
            $display("RESULT: FAIL");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    task automatic timeoutFail(input string what);
        $display("Timed out after %0d cycles waiting for %s", waitLimit, what);
        $display("RESULT: FAIL");
        $fatal(1, "timeout");
    endtask

    // Starts and ends 2 ns after a rising edge
    task automatic predictAt(input logic [tagePkg::addrBits-1:0] addr);
        int count;
        predValid = 1'b1;
        predAddr = addr;
        count = 0;
        @(negedge clk);
        while (!predReady) begin
            count++;
            if (count > waitLimit) timeoutFail("predReady");
            @(negedge clk);
        end
        gotTaken = predTaken;
        gotTageId = predTageId;
        gotUseful = predUseful;
        gotHistory = predHistory;
        @(posedge clk);
        #2;
        predValid = 1'b0;
    endtask

    task automatic updateWith(input logic [tagePkg::addrBits-1:0] addr,
                              input logic [tagePkg::historyLen-1:0] hist,
                              input logic [tagePkg::stageIdBits-1:0] id,
                              input logic taken,
                              input logic pred,
                              input logic [tagePkg::numStages-1:0] useful);
        int count;
        updValid = 1'b1;
        updAddr = addr;
        updHistory = hist;
        updTageId = id;
        updTaken = taken;
        updPred = pred;
        updUseful = useful;
        count = 0;
        @(negedge clk);
        while (!updReady) begin
            count++;
            if (count > waitLimit) timeoutFail("updReady");
            @(negedge clk);
        end
        @(posedge clk);
        modelHistory = {modelHistory[tagePkg::historyLen-2:0], taken};
        #2;
        updValid = 1'b0;
        checkValue("predHistory", modelHistory, predHistory);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stimulus
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin
        logic [tagePkg::addrBits-1:0] addrA;
        logic [tagePkg::addrBits-1:0] addrB;
        int count;
        lfsr = 16'd17;
        arstN = 1'b0;
        predValid = 1'b0;
        predAddr = '0;
        updValid = 1'b0;
        updAddr = '0;
        updHistory = '0;
        updTageId = '0;
        updTaken = 1'b0;
        updPred = 1'b0;
        updUseful = '0;
        modelHistory = '0;
        repeat (4) @(posedge clk);
        #2;
        arstN = 1'b1;

        // Sweep length itself is covered by the bound assertions
        count = 0;
        while (!(predReady && updReady)) begin
            count++;
            if (count > waitLimit) timeoutFail("the end of the reset sweep");
            @(posedge clk);
            #2;
        end

        // Cold tables predict weakly not taken from the base
        for (int i = 0; i < 8; i++) begin
            drawBits(tagePkg::addrBits, bits);
            predictAt(bits[tagePkg::addrBits-1:0]);
            checkValue("predTaken", 64'd0, 64'(gotTaken));
            checkValue("predTageId", 64'd0, 64'(gotTageId));
            checkValue("predUseful", 64'd0, 64'(gotUseful));
        end

        // Base training, no mispredict so nothing allocates
        drawBits(tagePkg::addrBits, bits);
        addrA = bits[tagePkg::addrBits-1:0];
        repeat (2) updateWith(addrA, predHistory, 3'd0, 1'b1, 1'b1, 5'b00000);
        predictAt(addrA);
        checkValue("predTaken", 64'd1, 64'(gotTaken));
        checkValue("predTageId", 64'd0, 64'(gotTageId));
        checkValue("predUseful", 64'h1F, 64'(gotUseful));

        // Low 8 history bits all ones survive a taken shift unchanged
        for (int i = 0; i < 8 && modelHistory[7:0] != 8'hFF; i++) begin
            updateWith(addrA, predHistory, 3'd0, 1'b1, 1'b1, 5'b11111);
        end

        // Mispredict on a cold base entry allocates into table 1
        drawBits(tagePkg::addrBits, bits);
        addrB = {bits[tagePkg::addrBits-1:8], addrA[7:0] ^ 8'h5A};
        predictAt(addrB);
        checkValue("predTaken", 64'd0, 64'(gotTaken));
        checkValue("predTageId", 64'd0, 64'(gotTageId));
        updateWith(addrB, gotHistory, gotTageId, 1'b1, gotTaken, gotUseful);
        predictAt(addrB);
        checkValue("predTageId", 64'd1, 64'(gotTageId));
        checkValue("predTaken", 64'd1, 64'(gotTaken));
        // Base moved from 1 to 2, weakly taken
        checkValue("predUseful[0]", 64'd1, 64'(gotUseful[0]));

        // Random traffic on both channels
        for (int i = 0; i < randomCycles; i++) begin
            drawBits(1, bits);
            predValid = bits[0];
            drawBits(tagePkg::addrBits, bits);
            predAddr = bits[tagePkg::addrBits-1:0];
            drawBits(1, bits);
            updValid = bits[0];
            drawBits(tagePkg::addrBits, bits);
            updAddr = bits[tagePkg::addrBits-1:0];
            drawBits(3, bits);
            updTageId = tagePkg::stageIdBits'(bits % 5);
            drawBits(1, bits);
            updTaken = bits[0];
            drawBits(1, bits);
            updPred = bits[0];
            drawBits(tagePkg::numStages, bits);
            updUseful = bits[tagePkg::numStages-1:0];
            updHistory = predHistory;
            @(negedge clk);
            checkValue("updReady", 64'd1, 64'(updReady));
            @(posedge clk);
            if (updValid) begin
                modelHistory = {modelHistory[tagePkg::historyLen-2:0], updTaken};
            end
            #2;
            checkValue("predHistory", modelHistory, predHistory);
        end
        predValid = 1'b0;
        updValid = 1'b0;
        repeat (2) @(posedge clk);

        $display("RESULT: PASS");
        $finish;
    end

endmodule

//--- tbBranchPredictor_properties.sv
module branchPredictorProperties (
    input logic                            clk,
    input logic                            arstN,

    input logic                            predValid,
    input logic                            predReady,
    input logic                            predTaken,
    input logic [tagePkg::stageIdBits-1:0] predTageId,
    input logic [tagePkg::numStages-1:0]   predUseful,
    input logic [tagePkg::historyLen-1:0]  predHistory,

    input logic                            updValid,
    input logic                            updReady,
    input logic                            updTaken
);

    timeunit 1ns;
    timeprecision 1ps;

    // Edges seen since arstN rose, saturating at the sweep length
    int unsigned sinceReset;
    logic        sweepDone;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            sinceReset <= 0;
        end else if (sinceReset < tagePkg::sweepCycles) begin
            sinceReset <= sinceReset + 1;
        end
    end

    assign sweepDone = sinceReset >= tagePkg::sweepCycles;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Handshake timing
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    readyAfterSweep: assert property (@(posedge clk) disable iff (!arstN)
        predReady == sweepDone && updReady == sweepDone)
        else $error("a ready does not rise exactly at the end of the sweep");

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // History register
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    historyShifts: assert property (@(posedge clk) disable iff (!arstN)
        updValid && updReady |=>
            predHistory == {$past(predHistory[tagePkg::historyLen-2:0]), $past(updTaken)})
        else $error("history did not shift in the resolved outcome");

    historyHolds: assert property (@(posedge clk) disable iff (!arstN)
        !(updValid && updReady) |=> predHistory == $past(predHistory))
        else $error("history changed without an accepted update");

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Prediction outputs
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    providerInRange: assert property (@(posedge clk) disable iff (!arstN)
        predValid && predReady |-> predTageId <= 3'd4)
        else $error("predTageId above the last tagged table");

    providerAgrees: assert property (@(posedge clk) disable iff (!arstN)
        predValid && predReady |-> predUseful[predTageId] == predTaken)
        else $error("predUseful at the provider differs from predTaken");

endmodule

bind branchPredictorTop branchPredictorProperties props (.*);

//--- verilog.f
tagePkg.sv
branchPredictionTable.sv
tageTable.sv
branchHistory.sv
tagePredictor.sv
branchPredictorTop.sv
tbBranchPredictor_properties.sv
tbBranchPredictor.sv
